// ==== src/mips_macros.svh ====
// MIPS core sizing macros
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Data and instruction word width
`define WORD_BITS 32

// Depth of instruction and data memories, in words
`define MEM_WORDS 128

// Word index width for a MEM_WORDS deep memory
`define MEM_ADDR_BITS 7

// Register file index width
`define REG_ADDR_BITS 5

`endif

// ==== src/mips_pkg.sv ====
// MIPS core shared types
`default_nettype none

package mips_pkg;

    // Primary opcode field in bits 31:26
    typedef enum logic [5:0] {
        op_special = 6'd0,   // R-type with function in bits 5:0
        op_addi    = 6'd8,
        op_lw      = 6'd35,
        op_sw      = 6'd43
    } opcode_t;

    // Function field of R-type words
    typedef enum logic [5:0] {
        f_add = 6'd32,
        f_sub = 6'd34,
        f_and = 6'd36,
        f_or  = 6'd37,
        f_slt = 6'd42
    } funct_t;

    // Operations carried into the execute stage
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt   // Signed compare
    } alu_op_t;

endpackage

`default_nettype wire

// ==== src/word_ram.sv ====
// Word memory with reset fill
`timescale 1ns/1ps
`include "mips_macros.svh"
`default_nettype none

module word_ram #(
    parameter bit fill_index = 1'b0  // 1 loads word i with i on reset
) (
    input  wire                        clock,
    input  wire                        reset,
    input  wire  [`MEM_ADDR_BITS-1:0]  addr,
    input  wire  [`WORD_BITS-1:0]      data_in,
    input  wire                        write,
    output logic [`WORD_BITS-1:0]      data_out
);

    logic [`WORD_BITS-1:0] mem [0:`MEM_WORDS-1];

    assign data_out = mem[addr];  // Combinational read

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                if (fill_index) begin
                    mem[i] <= `WORD_BITS'(i);  // Data image holds each word's index
                end else begin
                    mem[i] <= '0;              // All nops
                end
            end
        end else if (write) begin
            mem[addr] <= data_in;
        end
    end

endmodule

`default_nettype wire

// ==== src/fetch_decode.sv ====
// Fetch and decode stage
`timescale 1ns/1ps
`include "mips_macros.svh"
`default_nettype none

module fetch_decode import mips_pkg::*; (
    input  wire                        clock,
    input  wire                        reset,
    input  wire                        run,
    input  wire                        prog_write,
    input  wire  [`MEM_ADDR_BITS-1:0]  prog_addr,
    input  wire  [`WORD_BITS-1:0]      prog_data,
    input  wire                        wb_write,
    input  wire  [`REG_ADDR_BITS-1:0]  wb_index,
    input  wire  [`WORD_BITS-1:0]      wb_value,
    output alu_op_t                    ex_op,
    output logic [`WORD_BITS-1:0]      ex_a,
    output logic [`WORD_BITS-1:0]      ex_b,
    output logic [15:0]                ex_imm,
    output logic                       ex_use_imm,
    output logic [`REG_ADDR_BITS-1:0]  ex_dest,
    output logic                       ex_write,
    output logic                       ex_load,
    output logic                       ex_store
);

    logic [`MEM_ADDR_BITS-1:0] pc;
    logic [`MEM_ADDR_BITS-1:0] imem_addr;
    logic [`WORD_BITS-1:0]     imem_data;
    logic [`WORD_BITS-1:0]     ir;
    logic [`WORD_BITS-1:0]     regs [0:(1 << `REG_ADDR_BITS)-1];
    logic [`REG_ADDR_BITS-1:0] rs, rt, rd;
    logic [`WORD_BITS-1:0]     rs_value, rt_value;
    opcode_t                   opcode;
    funct_t                    funct;
    alu_op_t                   dec_op;
    logic                      dec_use_imm;
    logic [`REG_ADDR_BITS-1:0] dec_dest;
    logic                      dec_write, dec_load, dec_store;

    // Loader owns the memory port while stopped
    assign imem_addr = run ? pc : prog_addr;

    word_ram #(.fill_index(1'b0)) imem (
        .clock    (clock),
        .reset    (reset),
        .addr     (imem_addr),
        .data_in  (prog_data),
        .write    (prog_write && !run),
        .data_out (imem_data)
    );

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pc <= '0;
            ir <= '0;
        end else if (run) begin
            pc <= pc + 1'b1;
            ir <= imem_data;
        end else begin
            pc <= '0;
            ir <= '0;  // Nop while stopped
        end
    end

    // Field extraction
    assign opcode = opcode_t'(ir[31:26]);
    assign funct  = funct_t'(ir[5:0]);
    assign rs     = ir[25:21];
    assign rt     = ir[20:16];
    assign rd     = ir[15:11];

    assign rs_value = (rs == '0) ? '0 : regs[rs];
    assign rt_value = (rt == '0) ? '0 : regs[rt];

    always_comb begin
        dec_op      = alu_add;
        dec_use_imm = 1'b0;
        dec_dest    = rd;
        dec_write   = 1'b0;
        dec_load    = 1'b0;
        dec_store   = 1'b0;
        case (opcode)
            op_special: begin
                dec_write = 1'b1;
                case (funct)
                    f_add:   dec_op = alu_add;
                    f_sub:   dec_op = alu_sub;
                    f_and:   dec_op = alu_and;
                    f_or:    dec_op = alu_or;
                    f_slt:   dec_op = alu_slt;
                    default: dec_write = 1'b0;  // Unknown function, nop
                endcase
            end
            op_addi: begin
                dec_use_imm = 1'b1;
                dec_dest    = rt;
                dec_write   = 1'b1;
            end
            op_lw: begin
                dec_use_imm = 1'b1;
                dec_dest    = rt;
                dec_write   = 1'b1;
                dec_load    = 1'b1;
            end
            op_sw: begin
                dec_use_imm = 1'b1;
                dec_store   = 1'b1;
            end
            default: ;
        endcase
        // Writes to r0 are dropped here
        if (dec_dest == '0) begin
            dec_write = 1'b0;
        end
    end

    // Register file written from the result stage
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < (1 << `REG_ADDR_BITS); i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write) begin
            regs[wb_index] <= wb_value;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ex_write <= 1'b0;
            ex_load  <= 1'b0;
            ex_store <= 1'b0;
        end else begin
            ex_write <= dec_write;
            ex_load  <= dec_load;
            ex_store <= dec_store;
        end
    end

    always_ff @(posedge clock) begin
        ex_op      <= dec_op;
        ex_a       <= rs_value;
        ex_b       <= rt_value;   // Also the store data
        ex_imm     <= ir[15:0];
        ex_use_imm <= dec_use_imm;
        ex_dest    <= dec_dest;
    end

    // Loading is only legal with the core stopped
    assert property (@(posedge clock) disable iff (!reset) !(prog_write && run))
        else $error("program write while core is running");

endmodule

`default_nettype wire

// ==== src/alu_execute.sv ====
// Execute stage with ALU
`timescale 1ns/1ps
`include "mips_macros.svh"
`default_nettype none

module alu_execute import mips_pkg::*; (
    input  wire                        clock,
    input  wire                        reset,
    input  wire alu_op_t               ex_op,
    input  wire  [`WORD_BITS-1:0]      ex_a,
    input  wire  [`WORD_BITS-1:0]      ex_b,
    input  wire  [15:0]                ex_imm,
    input  wire                        ex_use_imm,
    input  wire  [`REG_ADDR_BITS-1:0]  ex_dest,
    input  wire                        ex_write,
    input  wire                        ex_load,
    input  wire                        ex_store,
    output logic [`WORD_BITS-1:0]      mem_value,
    output logic [`WORD_BITS-1:0]      mem_store_data,
    output logic [`REG_ADDR_BITS-1:0]  mem_dest,
    output logic                       mem_write,
    output logic                       mem_load,
    output logic                       mem_store
);

    logic [`WORD_BITS-1:0] imm_ext;
    logic [`WORD_BITS-1:0] operand_b;
    logic [`WORD_BITS-1:0] alu_out;

    assign imm_ext   = {{(`WORD_BITS-16){ex_imm[15]}}, ex_imm};  // Sign extend
    assign operand_b = ex_use_imm ? imm_ext : ex_b;

    // Loads and stores arrive as alu_add for the byte address
    always_comb begin
        case (ex_op)
            alu_add: alu_out = ex_a + operand_b;
            alu_sub: alu_out = ex_a - operand_b;
            alu_and: alu_out = ex_a & operand_b;
            alu_or:  alu_out = ex_a | operand_b;
            alu_slt: alu_out = `WORD_BITS'($signed(ex_a) < $signed(operand_b));
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            mem_write <= 1'b0;
            mem_load  <= 1'b0;
            mem_store <= 1'b0;
        end else begin
            mem_write <= ex_write;
            mem_load  <= ex_load;
            mem_store <= ex_store;
        end
    end

    always_ff @(posedge clock) begin
        mem_value      <= alu_out;
        mem_store_data <= ex_b;
        mem_dest       <= ex_dest;
    end

    // Decode never marks one word as both
    assert property (@(posedge clock) disable iff (!reset) !(ex_load && ex_store))
        else $error("load and store flagged together in execute");

endmodule

`default_nettype wire

// ==== src/mem_result.sv ====
// Data memory and write-back stage
`timescale 1ns/1ps
`include "mips_macros.svh"
`default_nettype none

module mem_result (
    input  wire                        clock,
    input  wire                        reset,
    input  wire  [`WORD_BITS-1:0]      mem_value,
    input  wire  [`WORD_BITS-1:0]      mem_store_data,
    input  wire  [`REG_ADDR_BITS-1:0]  mem_dest,
    input  wire                        mem_write,
    input  wire                        mem_load,
    input  wire                        mem_store,
    output logic                       wb_write,
    output logic [`REG_ADDR_BITS-1:0]  wb_index,
    output logic [`WORD_BITS-1:0]      wb_value
);

    logic [`WORD_BITS-1:0] dmem_data;

    // Byte address to word index with upper bits ignored
    word_ram #(.fill_index(1'b1)) dmem (
        .clock    (clock),
        .reset    (reset),
        .addr     (mem_value[`MEM_ADDR_BITS+1:2]),
        .data_in  (mem_store_data),
        .write    (mem_store),
        .data_out (dmem_data)
    );

    // Write-back in the same cycle as the access
    assign wb_write = mem_write;
    assign wb_index = mem_dest;
    assign wb_value = mem_load ? dmem_data : mem_value;

    // Only whole-word access exists
    assert property (@(posedge clock) disable iff (!reset)
        (mem_load || mem_store) |-> (mem_value[1:0] == 2'b00))
        else $error("unaligned data address %h", mem_value);

endmodule

`default_nettype wire

// ==== src/mips_core.sv ====
// MIPS subset core top level
`timescale 1ns/1ps
`include "mips_macros.svh"
`default_nettype none

module mips_core import mips_pkg::*; (
    input  wire                        clock,
    input  wire                        reset,
    input  wire                        run,
    input  wire                        prog_write,
    input  wire  [`MEM_ADDR_BITS-1:0]  prog_addr,
    input  wire  [`WORD_BITS-1:0]      prog_data,
    output wire                        reg_write,
    output wire  [`REG_ADDR_BITS-1:0]  reg_index,
    output wire  [`WORD_BITS-1:0]      reg_value
);

    // Decode to execute
    wire alu_op_t              ex_op;
    wire [`WORD_BITS-1:0]      ex_a, ex_b;
    wire [15:0]                ex_imm;
    wire                       ex_use_imm;
    wire [`REG_ADDR_BITS-1:0]  ex_dest;
    wire                       ex_write, ex_load, ex_store;

    // Execute to result
    wire [`WORD_BITS-1:0]      mem_value, mem_store_data;
    wire [`REG_ADDR_BITS-1:0]  mem_dest;
    wire                       mem_write, mem_load, mem_store;

    fetch_decode fd0 (
        .clock (clock), .reset (reset), .run (run),
        .prog_write (prog_write), .prog_addr (prog_addr), .prog_data (prog_data),
        .wb_write (reg_write), .wb_index (reg_index), .wb_value (reg_value),  // Write-back loop
        .ex_op (ex_op), .ex_a (ex_a), .ex_b (ex_b), .ex_imm (ex_imm),
        .ex_use_imm (ex_use_imm), .ex_dest (ex_dest),
        .ex_write (ex_write), .ex_load (ex_load), .ex_store (ex_store)
    );

    alu_execute ex0 (
        .clock (clock), .reset (reset),
        .ex_op (ex_op), .ex_a (ex_a), .ex_b (ex_b), .ex_imm (ex_imm),
        .ex_use_imm (ex_use_imm), .ex_dest (ex_dest),
        .ex_write (ex_write), .ex_load (ex_load), .ex_store (ex_store),
        .mem_value (mem_value), .mem_store_data (mem_store_data), .mem_dest (mem_dest),
        .mem_write (mem_write), .mem_load (mem_load), .mem_store (mem_store)
    );

    mem_result mr0 (
        .clock (clock), .reset (reset),
        .mem_value (mem_value), .mem_store_data (mem_store_data), .mem_dest (mem_dest),
        .mem_write (mem_write), .mem_load (mem_load), .mem_store (mem_store),
        .wb_write (reg_write), .wb_index (reg_index), .wb_value (reg_value)
    );

endmodule

`default_nettype wire

// ==== testbench/mips_core_tb.sv ====
// MIPS core testbench
`timescale 1ns/1ps
`include "mips_macros.svh"
`default_nettype none

module mips_core_tb import mips_pkg::*;;
    localparam int total_words = 4 * (6 + 40 + 5 + 5);  // Every instruction plus 3 nops
    localparam int cycle_limit = 4 * total_words + 200;

    logic clock, reset, run, prog_write;
    logic [`MEM_ADDR_BITS-1:0] prog_addr;
    logic [`WORD_BITS-1:0] prog_data;
    wire reg_write;
    wire [`REG_ADDR_BITS-1:0] reg_index;
    wire [`WORD_BITS-1:0] reg_value;

    logic [31:0] prog [0:`MEM_WORDS-1];
    logic [31:0] m_regs [0:31];
    logic [31:0] m_mem [0:`MEM_WORDS-1];
    logic [4:0] exp_idx [$];
    logic [31:0] exp_val [$];
    logic [31:0] lfsr = 32'd3;
    int prog_len, cycles, value_errors, other_errors;

    mips_core dut0 (.clock(clock), .reset(reset), .run(run), .prog_write(prog_write),
        .prog_addr(prog_addr), .prog_data(prog_data), .reg_write(reg_write),
        .reg_index(reg_index), .reg_value(reg_value));

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;  // Galois taps 32,22,2,1
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_r(input funct_t fn, input int rd, rs, rt);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(input opcode_t op, input int rt, rs, imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    // ISA model that runs the loaded words in order and lists expected writes
    function automatic void model_run();
        logic [31:0] w, a, b, imm, res;
        logic [4:0] dest;
        bit wr;
        for (int i = 0; i < prog_len; i++) begin
            w = prog[i];
            a = m_regs[w[25:21]];
            b = m_regs[w[20:16]];
            imm = {{16{w[15]}}, w[15:0]};
            wr = 1'b1;
            dest = w[20:16];
            res = a + imm;  // addi and the load/store byte address
            case (w[31:26])
                op_special: begin
                    dest = w[15:11];
                    case (w[5:0])
                        f_add: res = a + b;
                        f_sub: res = a - b;
                        f_and: res = a & b;
                        f_or: res = a | b;
                        f_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                op_addi: ;
                op_lw: res = m_mem[res[8:2]];
                op_sw: begin
                    m_mem[res[8:2]] = b;
                    wr = 1'b0;
                end
                default: wr = 1'b0;  // Nop
            endcase
            if (wr && dest != 5'd0) begin
                m_regs[dest] = res;
                exp_idx.push_back(dest);
                exp_val.push_back(res);
            end
        end
    endfunction

    // Compare every write-back against the expected list
    always @(posedge clock) begin
        if (reg_write !== 1'b0) begin
            if (run !== 1'b1 || reset !== 1'b1) begin
                other_errors++;
                $display("Register write at %0t while the core was stopped or in reset", $time);
            end else if (exp_idx.size() == 0) begin
                other_errors++;
                $display("Unexpected register write to r%0d at %0t", reg_index, $time);
            end else begin
                if (reg_index !== exp_idx[0]) begin
                    value_errors++;
                    $display("FAILED at %0t: reg_index expected %0d got %0d", $time,
                        exp_idx[0], reg_index);
                end
                if (reg_value !== exp_val[0]) begin
                    value_errors++;
                    $display("FAILED at %0t: reg_value expected %h got %h", $time,
                        exp_val[0], reg_value);
                end
                void'(exp_idx.pop_front());
                void'(exp_val.pop_front());
            end
        end
    end

    task automatic new_test();
        @(negedge clock);
        reset = 1'b0;
        repeat (3) @(negedge clock);
        reset = 1'b1;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            m_mem[i] = i;  // Data memory reset image
        end
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        exp_idx.delete();
        exp_val.delete();
        prog_len = 0;
    endtask

    task automatic add_instr(input logic [31:0] w);
        prog[prog_len] = w;
        for (int k = 1; k < 4; k++) begin
            prog[prog_len + k] = '0;  // Spacing nops
        end
        prog_len += 4;
    endtask

    task automatic run_program(input string name);
        int waited = 0;
        for (int i = 0; i < prog_len; i++) begin
            @(negedge clock);
            prog_write = 1'b1;
            prog_addr = i;
            prog_data = prog[i];
        end
        @(negedge clock);
        prog_write = 1'b0;
        model_run();
        run = 1'b1;
        while (exp_idx.size() > 0 && waited < prog_len + 8) begin
            @(negedge clock);
            waited++;
        end
        if (exp_idx.size() > 0) begin
            other_errors++;
            $display("%s: %0d expected register writes never appeared", name, exp_idx.size());
            exp_idx.delete();
            exp_val.delete();
        end
        repeat (8) @(negedge clock);  // Quiet cycles after the last write
        run = 1'b0;
    endtask

    task automatic random_alu_test(input int count);
        int kind;
        new_test();
        for (int n = 0; n < count; n++) begin
            kind = rand_bits(3) % 6;
            case (kind)
                0: add_instr(enc_r(f_add, rand_bits(3), rand_bits(3), rand_bits(3)));
                1: add_instr(enc_r(f_sub, rand_bits(3), rand_bits(3), rand_bits(3)));
                2: add_instr(enc_r(f_and, rand_bits(3), rand_bits(3), rand_bits(3)));
                3: add_instr(enc_r(f_or, rand_bits(3), rand_bits(3), rand_bits(3)));
                4: add_instr(enc_r(f_slt, rand_bits(3), rand_bits(3), rand_bits(3)));
                default: add_instr(enc_i(op_addi, rand_bits(3), rand_bits(3), rand_bits(16)));
            endcase
        end
        run_program("random ALU");
    endtask

    initial begin
        reset = 1'b0;
        run = 1'b0;
        prog_write = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        value_errors = 0;
        other_errors = 0;

        new_test();  // Reference program
        add_instr(enc_i(op_addi, 1, 0, 5));
        add_instr(enc_i(op_addi, 2, 0, 20));
        add_instr(enc_i(op_sw, 1, 2, 8));    // Word 7
        add_instr(enc_i(op_lw, 3, 0, 28));
        add_instr(enc_i(op_lw, 4, 0, 12));   // Untouched word 3
        add_instr(enc_r(f_add, 5, 3, 4));
        run_program("reference program");

        random_alu_test(20);  // Two runs fit the 128-word memory
        random_alu_test(20);

        new_test();  // Store then load and a load of an untouched word
        add_instr(enc_i(op_addi, 6, 0, -1234));
        add_instr(enc_i(op_sw, 6, 0, 400));
        add_instr(enc_i(op_lw, 7, 0, 400));
        add_instr(enc_i(op_lw, 8, 0, 404));
        add_instr(enc_r(f_sub, 9, 7, 8));
        run_program("memory");

        new_test();  // Register 0 stays zero
        add_instr(enc_i(op_addi, 0, 0, 77));
        add_instr(enc_i(op_addi, 1, 0, 9));
        add_instr(enc_r(f_add, 0, 1, 1));
        add_instr(enc_r(f_or, 10, 0, 1));
        add_instr(enc_r(f_add, 11, 0, 0));
        run_program("register 0");

        $display("Errors: %0d value mismatches, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clock);
            cycles++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycles);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+src
src/mips_pkg.sv
src/word_ram.sv
src/fetch_decode.sv
src/alu_execute.sv
src/mem_result.sv
src/mips_core.sv
testbench/mips_core_tb.sv
